// ==== flist.f ====
source/clkPkg.sv
source/clkDiagDecode.sv
source/clkBurstCounter.sv
source/clkGateCtl.sv
source/clkDiagRead.sv
source/clkCtl.sv
bench/clkCtl_assert.sv
bench/clkCtlTb.sv

// ==== bench/clkCtlInput.txt ====
# name op sel data expect, all hex; read expects readData
# wait: sel picks counter 0 crm 1 edp 2 ctl, data is idle cycles
rstStatus    read 0 0 04
rstIdle      wait 0 8 00
loadLow      ld   2 5 00
loadHigh     ld   3 a 00
readModes    read 1 0 0a
readLow      read 2 0 05
clrReset     ctl  6 0 00
burstLow     ld   2 6 00
clrStatus    read 0 0 00
setReset     ctl  7 0 00
burstHigh    ld   3 0 00
setStatus    read 0 0 04
burstRun     ctl  5 0 00
burstCount   wait 0 a 06
burstEmpty   read 2 0 00
zeroBurst    ctl  5 0 00
zeroCount    wait 0 6 00
runStart     ctl  1 0 00
runCount     wait 0 5 04
stepRun      ctl  2 0 00
stepCount    wait 0 6 01
stepStatus   read 0 0 04
errEnable    ld   7 8 00
errStart     ctl  1 0 00
errBefore    wait 0 5 04
errPulse     err  0 0 00
errAfter     wait 0 a 04
errStatus    read 0 0 0e
errRestart   ctl  1 0 00
crmDisable   ld   5 2 00
errCleared   read 0 0 27
disStart     ctl  1 0 00
disCrm       wait 0 6 00
disEdp       wait 1 0 05
disCtl       wait 2 0 05

// ==== bench/clkCtlTb.sv ====
//**********************************************************
// Clock control testbench
// Runs diagnostic functions from a file and counts enables
//**********************************************************
module clkCtlTb;

  timeunit 1ns;
  timeprecision 100ps;

  import clkPkg::*;

  logic     CLK;
  logic     arstN;
  logic     diagCtlFunc;
  logic     diagLdFunc;
  diagSelT  diagSel;
  diagDataT diagData;
  logic     diagRead;
  logic     errorIn;
  logic     clkEnCrm;
  logic     clkEnEdp;
  logic     clkEnCtl;
  logic     mrReset;
  readDataT readData;

  string nameQ[$];
  string opQ[$];
  int    selQ[$];
  int    dataQ[$];
  int    expQ[$];
  int    pulseCount[3];
  int    errorCount;
  int    checkCount;
  int    limitCycles;

  clkCtl #(.burstWidth(burstCountW)) clkCtl_inst (.*);

  always #10 CLK = ~CLK;

  // Enables are sampled on the falling edge, where they are stable
  task automatic nextCycle();
    @(negedge CLK);
    pulseCount[0] += int'(clkEnCrm);
    pulseCount[1] += int'(clkEnEdp);
    pulseCount[2] += int'(clkEnCtl);
  endtask

  task automatic checkValue(input string name, input int expected, input int actual);
    checkCount++;
    if (actual != expected) begin
      errorCount++;
      $display("Fail %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic loadStimulus();
    int    fd;
    string line;
    string name;
    string op;
    int    sel;
    int    data;
    int    expected;
    fd = $fopen("bench/clkCtlInput.txt", "r");
    limitCycles = 20;
    if (fd == 0) begin
      errorCount++;
      $display("Could not open the stimulus file bench/clkCtlInput.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != "#" &&
            $sscanf(line, "%s %s %h %h %h", name, op, sel, data, expected) == 5) begin
          nameQ.push_back(name);
          opQ.push_back(op);
          selQ.push_back(sel);
          dataQ.push_back(data);
          expQ.push_back(expected);
          limitCycles += 20 + ((op == "wait") ? data : 0);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic watchdog();
    repeat (limitCycles) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the run did not complete", limitCycles);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic runOp(input int idx);
    case (opQ[idx])
      "ctl": begin
        diagCtlFunc = 1'b1;
        diagSel     = diagSelT'(selQ[idx]);
        nextCycle();
        diagCtlFunc = 1'b0;
        // Enable from the previous function still lands in this cycle
        pulseCount  = '{0, 0, 0};
      end
      "ld": begin
        diagLdFunc = 1'b1;
        diagSel    = diagSelT'(selQ[idx]);
        diagData   = diagDataT'(dataQ[idx]);
        nextCycle();
        diagLdFunc = 1'b0;
        // Load reaches the registers one cycle after its strobe
        nextCycle();
      end
      "read": begin
        diagRead = 1'b1;
        diagSel  = diagSelT'(selQ[idx]);
        nextCycle();
        diagRead = 1'b0;
        checkValue(nameQ[idx], expQ[idx], int'(readData));
        // Master reset output matches bit 2 of the status word
        if (selQ[idx] == int'(rdStatus)) begin
          checkValue({nameQ[idx], "Out"}, (expQ[idx] >> 2) & 1, int'(mrReset));
        end
      end
      "err": begin
        errorIn = 1'b1;
        nextCycle();
        errorIn = 1'b0;
      end
      "wait": begin
        repeat (dataQ[idx]) nextCycle();
        checkValue(nameQ[idx], expQ[idx], pulseCount[selQ[idx]]);
      end
      default: begin
        errorCount++;
        $display("Unknown operation %s on stimulus line %s", opQ[idx], nameQ[idx]);
      end
    endcase
  endtask

  initial begin
    CLK         = 1'b0;
    arstN       = 1'b1;
    diagCtlFunc = 1'b0;
    diagLdFunc  = 1'b0;
    diagSel     = '0;
    diagData    = '0;
    diagRead    = 1'b0;
    errorIn     = 1'b0;
    errorCount  = 0;
    checkCount  = 0;
    pulseCount  = '{0, 0, 0};
    loadStimulus();
    fork
      watchdog();
    join_none
    #1 arstN = 1'b0;
    repeat (5) @(negedge CLK);
    arstN      = 1'b1;
    pulseCount = '{0, 0, 0};
    foreach (opQ[i]) begin
      runOp(i);
    end
    nextCycle();
    $display("Checks run %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/clkCtl_assert.sv ====
//**********************************************************
// Gate controller checks, bound into every clkGateCtl
//**********************************************************
module clkGateCtlAssert (
  input logic CLK,
  input logic arstN,
  input logic running,
  input logic bursting,
  input logic burstDec,
  input logic burstZero,
  input logic clkEnCrm,
  input logic clkEnEdp,
  input logic clkEnCtl
);

  timeunit 1ns;
  timeprecision 100ps;

  // Run and burst are separate states
  runBurstExclusive: assert property (@(posedge CLK) disable iff (!arstN)
    !(running && bursting))
    else $error("running and bursting are high together");

  noDecAtZero: assert property (@(posedge CLK) disable iff (!arstN)
    !(burstDec && burstZero))
    else $error("burstDec issued with an empty burst count");

  // Enables held low while reset is asserted
  noEnableInReset: assert property (@(posedge CLK)
    !arstN |-> !(clkEnCrm || clkEnEdp || clkEnCtl))
    else $error("clock enable high during reset");

endmodule

bind clkGateCtl clkGateCtlAssert clkGateCtlAssert_inst (.*);

// ==== source/clkCtl.sv ====
//**********************************************************
// Clock control top level
// Diagnostic decoder, burst counter, gate control and read
//**********************************************************
module clkCtl #(
  parameter int burstWidth = clkPkg::burstCountW
) (
  input  logic            CLK,
  input  logic            arstN,
  input  logic            diagCtlFunc,
  input  logic            diagLdFunc,
  input  clkPkg::diagSelT  diagSel,
  input  clkPkg::diagDataT diagData,
  input  logic            diagRead,
  input  logic            errorIn,
  output logic            clkEnCrm,
  output logic            clkEnEdp,
  output logic            clkEnCtl,
  output logic            mrReset,
  output clkPkg::readDataT readData
);

  import clkPkg::*;

  logic       startPulse;
  logic       stepPulse;
  logic       burstPulse;
  logic       loadLow;
  logic       loadHigh;
  diagDataT   loadData;
  logic       crmDis;
  logic       edpDis;
  logic       ctlDis;
  logic       errStopEn;
  burstCountT burstCount;
  logic       burstZero;
  logic       burstDec;
  logic       running;
  logic       bursting;
  logic       errorStop;

  clkDiagDecode clkDiagDecode_inst (
    .CLK(CLK), .arstN(arstN),
    .diagCtlFunc(diagCtlFunc), .diagLdFunc(diagLdFunc),
    .diagSel(diagSel), .diagData(diagData),
    .startPulse(startPulse), .stepPulse(stepPulse), .burstPulse(burstPulse),
    .loadLow(loadLow), .loadHigh(loadHigh), .loadData(loadData),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .errStopEn(errStopEn), .mrReset(mrReset)
  );

  clkBurstCounter #(
    .burstWidth(burstWidth)
  ) clkBurstCounter_inst (
    .CLK(CLK), .arstN(arstN),
    .loadLow(loadLow), .loadHigh(loadHigh), .loadData(loadData),
    .burstDec(burstDec), .burstCount(burstCount), .burstZero(burstZero)
  );

  clkGateCtl clkGateCtl_inst (
    .CLK(CLK), .arstN(arstN),
    .startPulse(startPulse), .stepPulse(stepPulse), .burstPulse(burstPulse),
    .burstZero(burstZero), .errorIn(errorIn), .errStopEn(errStopEn),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .clkEnCrm(clkEnCrm), .clkEnEdp(clkEnEdp), .clkEnCtl(clkEnCtl),
    .burstDec(burstDec), .running(running), .bursting(bursting),
    .errorStop(errorStop)
  );

  clkDiagRead clkDiagRead_inst (
    .CLK(CLK), .arstN(arstN),
    .diagRead(diagRead), .diagSel(diagSel),
    .running(running), .bursting(bursting), .errorStop(errorStop),
    .mrReset(mrReset), .errStopEn(errStopEn),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .burstCount(burstCount), .readData(readData)
  );

endmodule

// ==== source/clkDiagRead.sv ====
//**********************************************************
// Diagnostic status read
//**********************************************************
module clkDiagRead (
  input  logic              CLK,
  input  logic              arstN,
  input  logic              diagRead,
  input  clkPkg::diagSelT    diagSel,
  input  logic              running,
  input  logic              bursting,
  input  logic              errorStop,
  input  logic              mrReset,
  input  logic              errStopEn,
  input  logic              crmDis,
  input  logic              edpDis,
  input  logic              ctlDis,
  input  clkPkg::burstCountT burstCount,
  output clkPkg::readDataT   readData
);

  import clkPkg::*;

  readDataT readNext;

  // Status layout, most significant bit first
  always_comb begin
    case (diagSel)
      rdStatus:   readNext = {running, bursting, errorStop, mrReset, errStopEn, crmDis};
      rdModes:    readNext = {edpDis, ctlDis, burstCount[7:4]};
      rdBurstLow: readNext = {2'b00, burstCount[3:0]};
      default:    readNext = '0;
    endcase
  end

  // Word reads as zero whenever no read is in progress
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      readData <= '0;
    end else begin
      readData <= diagRead ? readNext : '0;
    end
  end

endmodule

// ==== source/clkGateCtl.sv ====
//**********************************************************
// Processor clock gate controller
// Run, single step and burst enables with error stop
//**********************************************************
module clkGateCtl (
  input  logic CLK,
  input  logic arstN,
  input  logic startPulse,
  input  logic stepPulse,
  input  logic burstPulse,
  input  logic burstZero,
  input  logic errorIn,
  input  logic errStopEn,
  input  logic crmDis,
  input  logic edpDis,
  input  logic ctlDis,
  output logic clkEnCrm,
  output logic clkEnEdp,
  output logic clkEnCtl,
  output logic burstDec,
  output logic running,
  output logic bursting,
  output logic errorStop
);

  import clkPkg::*;

  gateStateE gateState;
  gateStateE gateNext;
  logic      anyPulse;
  logic      errHit;
  logic      issueOk;
  logic      enNext;

  assign anyPulse = startPulse | stepPulse | burstPulse;
  // A new control function takes precedence over an error stop
  assign errHit  = errorIn & errStopEn & ~anyPulse;
  assign issueOk = ~anyPulse & ~errHit;

  always_comb begin
    case (gateState)
      gateStep:  gateNext = gateStopped;
      gateBurst: gateNext = burstZero ? gateStopped : gateBurst;
      default:   gateNext = gateState;
    endcase
    if (startPulse) begin
      gateNext = gateRunning;
    end else if (stepPulse) begin
      gateNext = gateStep;
    end else if (burstPulse) begin
      gateNext = gateBurst;
    end else if (errHit) begin
      gateNext = gateStopped;
    end
  end

  assign running  = (gateState == gateRunning);
  assign bursting = (gateState == gateBurst);

  // No enable in the cycle a new function or error arrives
  assign enNext = issueOk & (running | (gateState == gateStep) | (bursting & ~burstZero));

  // Each burst enable consumes one count
  assign burstDec = issueOk & bursting & ~burstZero;

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      gateState <= gateStopped;
      clkEnCrm  <= 1'b0;
      clkEnEdp  <= 1'b0;
      clkEnCtl  <= 1'b0;
      errorStop <= 1'b0;
    end else begin
      gateState <= gateNext;
      clkEnCrm  <= enNext & ~crmDis;
      clkEnEdp  <= enNext & ~edpDis;
      clkEnCtl  <= enNext & ~ctlDis;
      if (startPulse) begin
        errorStop <= 1'b0;
      end else if (errHit) begin
        errorStop <= 1'b1;
      end
    end
  end

endmodule

// ==== source/clkBurstCounter.sv ====
//**********************************************************
// Burst counter
// Nibble-loaded count of pending burst enable pulses
//**********************************************************
module clkBurstCounter #(
  parameter int burstWidth = clkPkg::burstCountW
) (
  input  logic              CLK,
  input  logic              arstN,
  input  logic              loadLow,
  input  logic              loadHigh,
  input  clkPkg::diagDataT   loadData,
  input  logic              burstDec,
  output clkPkg::burstCountT burstCount,
  output logic              burstZero
);

  import clkPkg::*;

  localparam logic [burstWidth-1:0] lowMask = burstWidth'(4'hF);

  logic [burstWidth-1:0] count;
  logic [burstWidth-1:0] loadWide;

  assign loadWide = burstWidth'(loadData);

  // Low and high halves load separately, like two cascaded counter chips
  // High load places the nibble from bit 4 upward
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      count <= '0;
    end else if (loadLow) begin
      count <= (count & ~lowMask) | loadWide;
    end else if (loadHigh) begin
      count <= (count & lowMask) | (loadWide << 4);
    end else if (burstDec && count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign burstZero  = (count == '0);
  assign burstCount = burstCountT'(count);

endmodule

// ==== source/clkDiagDecode.sv ====
//**********************************************************
// Diagnostic function decoder
// Turns control and load strobes into pulses and mode bits
//**********************************************************
module clkDiagDecode (
  input  logic            CLK,
  input  logic            arstN,
  input  logic            diagCtlFunc,
  input  logic            diagLdFunc,
  input  clkPkg::diagSelT  diagSel,
  input  clkPkg::diagDataT diagData,
  output logic            startPulse,
  output logic            stepPulse,
  output logic            burstPulse,
  output logic            loadLow,
  output logic            loadHigh,
  output clkPkg::diagDataT loadData,
  output logic            crmDis,
  output logic            edpDis,
  output logic            ctlDis,
  output logic            errStopEn,
  output logic            mrReset
);

  import clkPkg::*;

  logic ctlValid;
  logic ldValid;
  logic clrResetPulse;
  logic setResetPulse;
  logic ldDisPulse;
  logic ldErrPulse;

  // Control wins when both strobes arrive together
  assign ctlValid = diagCtlFunc;
  assign ldValid  = diagLdFunc & ~diagCtlFunc;

  // One-cycle function pulses, registered from the sampled strobe
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      startPulse    <= 1'b0;
      stepPulse     <= 1'b0;
      burstPulse    <= 1'b0;
      clrResetPulse <= 1'b0;
      setResetPulse <= 1'b0;
      loadLow       <= 1'b0;
      loadHigh      <= 1'b0;
      ldDisPulse    <= 1'b0;
      ldErrPulse    <= 1'b0;
    end else begin
      startPulse    <= ctlValid && (diagSel == ctlStart);
      stepPulse     <= ctlValid && (diagSel == ctlSingleStep);
      burstPulse    <= ctlValid && (diagSel == ctlBurst);
      clrResetPulse <= ctlValid && (diagSel == ctlClrReset);
      setResetPulse <= ctlValid && (diagSel == ctlSetReset);
      loadLow       <= ldValid && (diagSel == ldBurstLow);
      loadHigh      <= ldValid && (diagSel == ldBurstHigh);
      ldDisPulse    <= ldValid && (diagSel == ldDisables);
      ldErrPulse    <= ldValid && (diagSel == ldErrStop);
    end
  end

  // Data nibble captured with each accepted load
  always_ff @(posedge CLK) begin
    if (ldValid) begin
      loadData <= diagData;
    end
  end

  // Mode registers and master reset flag
  // Power-up holds the processor in reset until a clear reset function
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      crmDis    <= 1'b0;
      edpDis    <= 1'b0;
      ctlDis    <= 1'b0;
      errStopEn <= 1'b0;
      mrReset   <= 1'b1;
    end else begin
      if (ldDisPulse) begin
        crmDis <= loadData[1];
        edpDis <= loadData[2];
        ctlDis <= loadData[3];
      end
      if (ldErrPulse) begin
        errStopEn <= loadData[3];
      end
      if (clrResetPulse) begin
        mrReset <= 1'b0;
      end else if (setResetPulse) begin
        mrReset <= 1'b1;
      end
    end
  end

endmodule

// ==== source/clkPkg.sv ====
//**********************************************************
// Clock control package
// Shared widths, diagnostic function codes and gate states
//**********************************************************
package clkPkg;

  // Field widths
  localparam int diagSelW    = 3;
  localparam int diagDataW   = 4;
  localparam int burstCountW = 8;
  localparam int readDataW   = 6;

  typedef logic [diagSelW-1:0]    diagSelT;
  typedef logic [diagDataW-1:0]   diagDataT;
  typedef logic [burstCountW-1:0] burstCountT;
  typedef logic [readDataW-1:0]   readDataT;

  // Control function codes
  localparam diagSelT ctlStart      = 3'd1;
  localparam diagSelT ctlSingleStep = 3'd2;
  localparam diagSelT ctlBurst      = 3'd5;
  localparam diagSelT ctlClrReset   = 3'd6;
  localparam diagSelT ctlSetReset   = 3'd7;

  // Load function codes
  localparam diagSelT ldBurstLow  = 3'd2;
  localparam diagSelT ldBurstHigh = 3'd3;
  localparam diagSelT ldDisables  = 3'd5;
  localparam diagSelT ldErrStop   = 3'd7;

  // Diagnostic read codes
  localparam diagSelT rdStatus   = 3'd0;
  localparam diagSelT rdModes    = 3'd1;
  localparam diagSelT rdBurstLow = 3'd2;

  // Processor clock gate states
  typedef enum logic [1:0] {
    gateStopped,
    gateRunning,
    gateBurst,
    gateStep
  } gateStateE;

endpackage
